// ==== rtl/av_rx_settings.svh ====
`ifndef AV_RX_SETTINGS_SVH
`define AV_RX_SETTINGS_SVH

// width of the start address that opens every packet.
`define AV_ADDR_W 24

// pixel bytes that follow the address in every packet.
`define AV_PIXELS_PER_PKT 320

// word address width of the external frame buffer.
`define AV_FB_ADDR_W 17

// audio FIFO depth in bytes, kept a power of two so the pointers wrap by themselves.
`define AV_AUDIO_DEPTH 16

`endif

// ==== rtl/av_rx_pkg.sv ====
`include "av_rx_settings.svh"

package av_rx_pkg;

    // one 2-bit symbol on the RMII-style link.
    typedef logic [1:0] dibit_t;

    // one pixel or audio sample.
    typedef logic [7:0] byte_t;

    typedef logic [`AV_ADDR_W-1:0] pkt_addr_t;

    typedef logic [`AV_FB_ADDR_W-1:0] fb_addr_t;

    // splitter phases within one packet.
    typedef enum logic [1:0] {
        recv_addr,
        recv_pixels,
        recv_audio
    } split_state_t;

endpackage

// ==== rtl/media_if.sv ====
`timescale 1ns/1ps

interface media_if;

    logic                  addr_strobe;  // one-cycle pulse when addr is complete.
    av_rx_pkg::pkt_addr_t  addr;
    logic                  pixel_strobe; // one-cycle pulse per pixel byte.
    av_rx_pkg::byte_t      pixel;

    modport splitter (
        output addr_strobe,
        output addr,
        output pixel_strobe,
        output pixel
    );

    modport writer (
        input addr_strobe,
        input addr,
        input pixel_strobe,
        input pixel
    );

endinterface

// ==== rtl/frame_sync.sv ====
`timescale 1ns/1ps

module frame_sync (
    input  logic              clk,
    input  logic              rst,
    input  logic              crs_dv,
    input  av_rx_pkg::dibit_t rxd,
    output logic              pay_valid,
    output av_rx_pkg::dibit_t pay_dibit
);

    localparam av_rx_pkg::dibit_t PREAMBLE_DIBIT = 2'b01;
    localparam av_rx_pkg::dibit_t SFD_DIBIT      = 2'b11;
    localparam int                PREAMBLE_MIN   = 4;

    logic [2:0] pre_cnt;  // saturates at PREAMBLE_MIN.
    logic       in_frame;
    logic       pre_ok;

    assign pre_ok = (pre_cnt == 3'(PREAMBLE_MIN));

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt   <= 3'd0;
            in_frame  <= 1'b0;
            pay_valid <= 1'b0;
        end else if (!crs_dv) begin
            pre_cnt   <= 3'd0; // carrier gone, hunt again.
            in_frame  <= 1'b0;
            pay_valid <= 1'b0;
        end else if (in_frame) begin
            pay_valid <= 1'b1;
        end else begin
            pay_valid <= 1'b0;
            if (rxd == PREAMBLE_DIBIT) begin
                if (!pre_ok) begin
                    pre_cnt <= pre_cnt + 3'd1;
                end
            end else if (rxd == SFD_DIBIT && pre_ok) begin
                in_frame <= 1'b1; // next dibit is the first payload dibit.
                pre_cnt  <= 3'd0;
            end else begin
                pre_cnt <= 3'd0; // broken preamble.
            end
        end
    end

    // the payload dibit is only meaningful while pay_valid is high.
    always_ff @(posedge clk) begin
        pay_dibit <= rxd;
    end

endmodule

// ==== rtl/media_splitter.sv ====
`timescale 1ns/1ps
`include "av_rx_settings.svh"

module media_splitter (
    input  logic              clk,
    input  logic              rst,
    input  logic              pay_valid,
    input  av_rx_pkg::dibit_t pay_dibit,
    media_if.splitter         media,
    output logic              audio_strobe,
    output av_rx_pkg::byte_t  audio
);

    localparam int BYTE_CNT_W = $clog2(`AV_PIXELS_PER_PKT);
    localparam int ADDR_BYTES = `AV_ADDR_W / 8;

    av_rx_pkg::split_state_t state;
    logic [1:0]              dib_cnt;   // dibit position within the current byte.
    logic [BYTE_CNT_W-1:0]   byte_cnt;
    logic                    byte_done;
    logic                    addr_strobe_q;
    logic                    pixel_strobe_q;
    av_rx_pkg::pkt_addr_t    addr_q;
    av_rx_pkg::byte_t        byte_sh;

    assign byte_done = (dib_cnt == 2'd3);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= av_rx_pkg::recv_addr;
            dib_cnt        <= 2'd0;
            byte_cnt       <= '0;
            addr_strobe_q  <= 1'b0;
            pixel_strobe_q <= 1'b0;
            audio_strobe   <= 1'b0;
        end else begin
            addr_strobe_q  <= 1'b0;
            pixel_strobe_q <= 1'b0;
            audio_strobe   <= 1'b0;
            if (!pay_valid) begin
                state    <= av_rx_pkg::recv_addr; // a partial byte is dropped here.
                dib_cnt  <= 2'd0;
                byte_cnt <= '0;
            end else begin
                dib_cnt <= dib_cnt + 2'd1;
                case (state)
                    av_rx_pkg::recv_addr: begin
                        if (byte_done) begin
                            if (byte_cnt == BYTE_CNT_W'(ADDR_BYTES - 1)) begin
                                addr_strobe_q <= 1'b1;
                                byte_cnt      <= '0;
                                state         <= av_rx_pkg::recv_pixels;
                            end else begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                    end
                    av_rx_pkg::recv_pixels: begin
                        if (byte_done) begin
                            pixel_strobe_q <= 1'b1;
                            if (byte_cnt == BYTE_CNT_W'(`AV_PIXELS_PER_PKT - 1)) begin
                                byte_cnt <= '0;
                                state    <= av_rx_pkg::recv_audio;
                            end else begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                    end
                    av_rx_pkg::recv_audio: begin
                        if (byte_done) begin
                            audio_strobe <= 1'b1; // audio runs to the end of the packet.
                        end
                    end
                    default: state <= av_rx_pkg::recv_addr;
                endcase
            end
        end
    end

    // both shifters take the first dibit into the top bits.
    always_ff @(posedge clk) begin
        if (pay_valid) begin
            byte_sh <= {byte_sh[5:0], pay_dibit};
            if (state == av_rx_pkg::recv_addr) begin
                addr_q <= {addr_q[`AV_ADDR_W-3:0], pay_dibit};
            end
        end
    end

    assign media.addr_strobe  = addr_strobe_q;
    assign media.addr         = addr_q;
    assign media.pixel_strobe = pixel_strobe_q;
    assign media.pixel        = byte_sh;
    assign audio              = byte_sh;

    a_one_byte_kind: assert property (@(posedge clk) disable iff (rst)
        !(pixel_strobe_q && audio_strobe));

endmodule

// ==== rtl/pixel_writer.sv ====
`timescale 1ns/1ps
`include "av_rx_settings.svh"

module pixel_writer (
    input  logic                clk,
    input  logic                rst,
    media_if.writer             media,
    output logic                fb_we,
    output av_rx_pkg::fb_addr_t fb_addr,
    output av_rx_pkg::byte_t    fb_data
);

    av_rx_pkg::fb_addr_t base;
    av_rx_pkg::fb_addr_t pix_idx;   // pixel index within the current packet.
    logic                addr_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            fb_we     <= 1'b0;
            pix_idx   <= '0;
            addr_seen <= 1'b0;
        end else begin
            fb_we <= media.pixel_strobe;
            if (media.addr_strobe) begin
                pix_idx   <= '0;
                addr_seen <= 1'b1;
            end else if (media.pixel_strobe) begin
                pix_idx <= pix_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (media.addr_strobe) begin
            base <= media.addr[`AV_FB_ADDR_W-1:0]; // upper address bits select nothing here.
        end
        if (media.pixel_strobe) begin
            fb_addr <= base + pix_idx;
            fb_data <= media.pixel;
        end
    end

    // a write without a start address would land at an unknown location.
    a_addr_before_write: assert property (@(posedge clk) disable iff (rst)
        fb_we |-> addr_seen);

endmodule

// ==== rtl/audio_fifo.sv ====
`timescale 1ns/1ps
`include "av_rx_settings.svh"

module audio_fifo (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr,
    input  av_rx_pkg::byte_t wr_data,
    input  logic             pop,
    output av_rx_pkg::byte_t rd_data,
    output logic             empty,
    output logic             overflow
);

    localparam int DEPTH = `AV_AUDIO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    av_rx_pkg::byte_t mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = pop && !empty; // a pop on an empty FIFO is ignored.

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr     <= '0;
            rptr     <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            if (wr && full) begin
                overflow <= 1'b1; // sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= wr_data;
        end
    end

    // show-ahead read port.
    assign rd_data = mem[rptr];

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (PTR_W+1)'(DEPTH));

endmodule

// ==== rtl/av_stream_receiver.sv ====
`timescale 1ns/1ps

module av_stream_receiver (
    input  logic                clk,
    input  logic                rst,
    input  logic                crs_dv,
    input  av_rx_pkg::dibit_t   rxd,
    output logic                fb_we,
    output av_rx_pkg::fb_addr_t fb_addr,
    output av_rx_pkg::byte_t    fb_data,
    input  logic                audio_pop,
    output av_rx_pkg::byte_t    audio_out,
    output logic                audio_empty,
    output logic                audio_overflow
);

    logic              pay_valid;
    av_rx_pkg::dibit_t pay_dibit;
    logic              audio_strobe;
    av_rx_pkg::byte_t  audio;

    media_if media ();

    frame_sync u_frame_sync (
        .clk       (clk),
        .rst       (rst),
        .crs_dv    (crs_dv),
        .rxd       (rxd),
        .pay_valid (pay_valid),
        .pay_dibit (pay_dibit)
    );

    media_splitter u_media_splitter (
        .clk          (clk),
        .rst          (rst),
        .pay_valid    (pay_valid),
        .pay_dibit    (pay_dibit),
        .media        (media.splitter),
        .audio_strobe (audio_strobe),
        .audio        (audio)
    );

    pixel_writer u_pixel_writer (
        .clk     (clk),
        .rst     (rst),
        .media   (media.writer),
        .fb_we   (fb_we),
        .fb_addr (fb_addr),
        .fb_data (fb_data)
    );

    audio_fifo u_audio_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr       (audio_strobe),
        .wr_data  (audio),
        .pop      (audio_pop),
        .rd_data  (audio_out),
        .empty    (audio_empty),
        .overflow (audio_overflow)
    );

endmodule

// ==== verif/av_rx_tb_tasks.svh ====
`ifndef AV_RX_TB_TASKS_SVH
`define AV_RX_TB_TASKS_SVH

function automatic void push_preamble(input int n_pre, input bit with_sfd);
    for (int i = 0; i < n_pre; i++) begin
        link_q.push_back(2'b01);
    end
    if (with_sfd) begin
        link_q.push_back(2'b11);
    end
endfunction

// the most significant dibit goes onto the link first.
function automatic void push_bits(input logic [31:0] value, input int n_dibits);
    for (int i = n_dibits - 1; i >= 0; i--) begin
        link_q.push_back(value[2*i +: 2]);
    end
endfunction

function automatic void build_packet(
    input av_rx_pkg::pkt_addr_t addr,
    input av_rx_pkg::byte_t     pix[$],
    input av_rx_pkg::byte_t     aud[$]
);
    push_preamble(7, 1'b1);
    push_bits(32'(addr), 12);
    foreach (pix[i]) begin
        push_bits(32'(pix[i]), 4);
    end
    foreach (aud[i]) begin
        push_bits(32'(aud[i]), 4);
    end
endfunction

function automatic void fill_random(input int n_pix, input int n_aud);
    pix_q.delete();
    aud_q.delete();
    for (int i = 0; i < n_pix; i++) begin
        pix_q.push_back(av_rx_pkg::byte_t'($urandom));
    end
    for (int i = 0; i < n_aud; i++) begin
        aud_q.push_back(av_rx_pkg::byte_t'($urandom));
    end
endfunction

// queues the writes and audio bytes one packet should produce, returns the expected overflow.
function automatic bit expected_packet(
    input av_rx_pkg::pkt_addr_t addr,
    input av_rx_pkg::byte_t     pix[$],
    input av_rx_pkg::byte_t     aud[$],
    input int                   room
);
    av_rx_pkg::fb_addr_t wa;
    wa = addr[`AV_FB_ADDR_W-1:0];
    foreach (pix[k]) begin
        exp_fb_q.push_back({wa, pix[k]});
        wa = wa + 1'b1; // wraps inside the frame buffer.
    end
    foreach (aud[i]) begin
        if (i < room) begin
            exp_aud_q.push_back(aud[i]);
        end
    end
    return aud.size() > room;
endfunction

task automatic report_problem(input string msg);
    $display("%s", msg);
    stop_run();
endtask

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
        $display("Error in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        stop_run();
    end
endtask

task automatic send_link(input int idle_cycles);
    foreach (link_q[i]) begin
        @(posedge clk);
        #1;
        crs_dv = 1'b1;
        rxd    = link_q[i];
    end
    link_q.delete();
    repeat (idle_cycles) begin
        @(posedge clk);
        #1;
        crs_dv = 1'b0;
        rxd    = 2'b00;
    end
endtask

task automatic wait_drained(input string what, input bit with_audio, input int max_cycles);
    int waited;
    waited = 0;
    while (exp_fb_q.size() != 0 || (with_audio && exp_aud_q.size() != 0)) begin
        if (waited == max_cycles) begin
            report_problem($sformatf("timeout after %0d cycles waiting for %s",
                                     max_cycles, what));
        end
        @(negedge clk);
        #1;
        waited++;
    end
endtask

task automatic settle(input int n_cycles);
    repeat (n_cycles) begin
        @(negedge clk);
        #1;
    end
endtask

`endif

// ==== verif/av_stream_receiver_tb.sv ====
`timescale 1ns/1ps
`include "av_rx_settings.svh"

module av_stream_receiver_tb;

    logic                     clk;
    logic                     rst;
    logic                     crs_dv;
    av_rx_pkg::dibit_t        rxd;
    logic                     fb_we;
    av_rx_pkg::fb_addr_t      fb_addr;
    av_rx_pkg::byte_t         fb_data;
    logic                     audio_pop;
    av_rx_pkg::byte_t         audio_out;
    logic                     audio_empty;
    logic                     audio_overflow;

    av_rx_pkg::dibit_t        link_q[$];
    av_rx_pkg::byte_t         pix_q[$];
    av_rx_pkg::byte_t         aud_q[$];
    logic [`AV_FB_ADDR_W+7:0] exp_fb_q[$];   // {address, data} per write.
    av_rx_pkg::byte_t         exp_aud_q[$];
    logic [`AV_FB_ADDR_W+7:0] exp_write;
    string                    test_name;
    bit                       reader_en;
    int                       fb_count;
    int                       aud_count;

    `include "av_rx_tb_tasks.svh"

    av_stream_receiver UUT (
        .clk            (clk),
        .rst            (rst),
        .crs_dv         (crs_dv),
        .rxd            (rxd),
        .fb_we          (fb_we),
        .fb_addr        (fb_addr),
        .fb_data        (fb_data),
        .audio_pop      (audio_pop),
        .audio_out      (audio_out),
        .audio_empty    (audio_empty),
        .audio_overflow (audio_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(negedge clk) begin
        if (!rst && fb_we) begin
            fb_count++;
            if (exp_fb_q.size() == 0) begin
                report_problem($sformatf("unexpected frame-buffer write to 0x%0h in %s",
                                         fb_addr, test_name));
            end else begin
                exp_write = exp_fb_q.pop_front();
                check({test_name, " write address"}, exp_write[`AV_FB_ADDR_W+7:8], fb_addr);
                check({test_name, " write data"}, exp_write[7:0], fb_data);
            end
        end
    end

    // pops one byte per cycle while the FIFO holds data.
    initial begin
        audio_pop = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && reader_en && !audio_empty) begin
                audio_pop = 1'b1;
                aud_count++;
                if (exp_aud_q.size() == 0) begin
                    report_problem({"unexpected audio byte in ", test_name});
                end else begin
                    check({test_name, " audio byte"}, exp_aud_q.pop_front(), audio_out);
                end
            end else begin
                audio_pop = 1'b0;
            end
        end
    end

    task automatic run_packet(input int n_pix, input int n_aud);
        av_rx_pkg::pkt_addr_t addr;
        int                   fb_base;
        int                   aud_base;
        bit                   ovf;
        addr = av_rx_pkg::pkt_addr_t'($urandom);
        fill_random(n_pix, n_aud);
        ovf = expected_packet(addr, pix_q, aud_q, `AV_AUDIO_DEPTH);
        fb_base  = fb_count;
        aud_base = aud_count;
        build_packet(addr, pix_q, aud_q);
        send_link(6);
        wait_drained({"the writes and audio of ", test_name}, 1'b1, 200);
        settle(8);
        check({test_name, " write count"}, n_pix, fb_count - fb_base);
        check({test_name, " audio count"}, n_aud, aud_count - aud_base);
        check({test_name, " overflow"}, ovf, audio_overflow);
    endtask

    initial begin : test_seq
        av_rx_pkg::pkt_addr_t addr;
        bit                   ovf;
        void'($urandom(83));
        test_name = "reset";
        reader_en = 1'b1;
        fb_count  = 0;
        aud_count = 0;
        rst       = 1'b1;
        crs_dv    = 1'b0;
        rxd       = 2'b00;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle link with noise on rxd.
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            rxd = av_rx_pkg::dibit_t'($urandom);
            @(negedge clk);
            #1;
            check("reset fb_we", 0, fb_we);
            check("reset audio_overflow", 0, audio_overflow);
            check("reset audio_empty", 1, audio_empty);
        end

        test_name = "full packet";
        run_packet(`AV_PIXELS_PER_PKT, 8);

        // variant 0 breaks the preamble with 00, variant 1 never sends the SFD.
        for (int v = 0; v < 2; v++) begin
            test_name = (v == 0) ? "corrupt preamble" : "missing sfd";
            push_preamble((v == 0) ? 7 : 8, 1'b0);
            if (v == 0) begin
                push_bits(32'h0, 1);
                push_bits(32'h3, 1);
            end
            push_bits(32'h123456, 12);
            for (int b = 0; b < 8; b++) begin
                push_bits(32'hA0 + b, 4);
            end
            fb_count  = 0;
            aud_count = 0;
            send_link(6);
            settle(4);
            check({test_name, " write count"}, 0, fb_count);
            check({test_name, " audio count"}, 0, aud_count);
            check({test_name, " audio_empty"}, 1, audio_empty);
        end

        test_name = "cut packet";
        addr = av_rx_pkg::pkt_addr_t'($urandom);
        fill_random(100, 0);
        ovf = expected_packet(addr, pix_q, aud_q, `AV_AUDIO_DEPTH);
        build_packet(addr, pix_q, aud_q);
        push_bits($urandom, 2);
        fb_count = 0;
        send_link(6);
        wait_drained("the 100 writes of the cut packet", 1'b1, 200);
        settle(8);
        check("cut packet write count", 100, fb_count);

        test_name = "packet after cut";
        run_packet(`AV_PIXELS_PER_PKT, 4);

        test_name = "audio overflow";
        reader_en = 1'b0;
        addr = av_rx_pkg::pkt_addr_t'($urandom);
        fill_random(`AV_PIXELS_PER_PKT, 20);
        ovf = expected_packet(addr, pix_q, aud_q, `AV_AUDIO_DEPTH);
        build_packet(addr, pix_q, aud_q);
        send_link(6);
        wait_drained("the pixel writes of the overflow packet", 1'b0, 200);
        settle(2);
        check("audio overflow flag", ovf, audio_overflow);
        check("audio overflow fifo holds data", 0, audio_empty);
        aud_count = 0;
        reader_en = 1'b1;
        wait_drained("16 audio bytes from the full FIFO", 1'b1, 200);
        settle(4);
        check("audio overflow bytes read", `AV_AUDIO_DEPTH, aud_count);
        check("audio overflow drained", 1, audio_empty);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== av_stream_receiver.f ====
+incdir+rtl
+incdir+verif
rtl/av_rx_pkg.sv
rtl/media_if.sv
rtl/frame_sync.sv
rtl/media_splitter.sv
rtl/pixel_writer.sv
rtl/audio_fifo.sv
rtl/av_stream_receiver.sv
verif/av_stream_receiver_tb.sv

// ==== Bender.yml ====
package:
  name: av_stream_receiver

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/av_rx_pkg.sv
      - rtl/media_if.sv
      - rtl/frame_sync.sv
      - rtl/media_splitter.sv
      - rtl/pixel_writer.sv
      - rtl/audio_fifo.sv
      - rtl/av_stream_receiver.sv
  - target: test
    include_dirs:
      - rtl
      - verif
    files:
      - verif/av_stream_receiver_tb.sv
